// File: hw/mem_pkg.sv
`default_nettype none

package mem_pkg;

	// bus widths of the AXI-lite port
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	localparam int STRB_W = DATA_W / 8;

	// low address bits that select a byte inside a word
	localparam int BYTE_OFFSET_BITS = 3;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [STRB_W-1:0] strb_t;
	typedef logic [1:0]        resp_t;

	// word index inside one bank, checked against the bank depth
	typedef logic [31:0] index_t;

	// only these two codes are ever returned
	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	// read request into a bank
	typedef struct packed {
		index_t index;
	} rd_req_t;

	// write request into a bank, AW and W merged
	typedef struct packed {
		index_t index;
		data_t  data;
		strb_t  strb;
	} wr_req_t;

	// read response out of a bank
	typedef struct packed {
		data_t data;
		resp_t resp;
	} rd_rsp_t;

	// write response out of a bank
	typedef struct packed {
		resp_t resp;
	} wr_rsp_t;

endpackage

`default_nettype wire

// File: hw/resp_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module resp_fifo #(
	parameter type T = logic,
	parameter int DEPTH = 4
) (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic push,
	input  wire T     push_data,
	output logic      full,
	input  wire logic pop,
	output T          pop_data,
	output logic      empty
);

	// depth of at least two assumed
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	T mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	assign full  = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);

	// push into a full fifo or pop from an empty one is dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// head is visible without a pop
	assign pop_data = mem[rd_ptr];

	// storage, no reset
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// wrap by compare so depth need not be a power of two
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// simultaneous push and pop keep the count
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/bank_router.sv
`timescale 1ns/1ns
`default_nettype none

module bank_router #(
	parameter int NUM_BANKS = 4
) (
	input  wire logic                        clk,
	input  wire logic                        rst,
	// read address channel
	input  wire logic                        arvalid,
	input  wire mem_pkg::addr_t              araddr,
	output logic                             arready,
	// write address and data channels
	input  wire logic                        awvalid,
	input  wire mem_pkg::addr_t              awaddr,
	output logic                             awready,
	input  wire logic                        wvalid,
	input  wire mem_pkg::data_t              wdata,
	input  wire mem_pkg::strb_t              wstrb,
	output logic                             wready,
	// requests to the banks
	output logic [NUM_BANKS-1:0]             rd_req_valid,
	output mem_pkg::rd_req_t                 rd_req,
	input  wire logic [NUM_BANKS-1:0]        rd_req_ready,
	output logic [NUM_BANKS-1:0]             wr_req_valid,
	output mem_pkg::wr_req_t                 wr_req,
	input  wire logic [NUM_BANKS-1:0]        wr_req_ready,
	// issue reports to the merger
	output logic                             rd_issue,
	output logic [$clog2(NUM_BANKS)-1:0]     rd_issue_bank,
	output logic                             wr_issue,
	output logic [$clog2(NUM_BANKS)-1:0]     wr_issue_bank,
	input  wire logic                        rd_order_full,
	input  wire logic                        wr_order_full
);

	// bank select width, needs at least two banks
	localparam int BANK_W = $clog2(NUM_BANKS);
	localparam int INDEX_SHIFT = mem_pkg::BYTE_OFFSET_BITS + BANK_W;

	logic [BANK_W-1:0] rd_bank;
	logic [BANK_W-1:0] wr_bank;
	logic              rd_go;
	logic              wr_go;
	logic              live;

	// nothing is accepted until the first cycle out of reset
	always_ff @(posedge clk) begin
		if (rst) begin
			live <= 1'b0;
		end else begin
			live <= 1'b1;
		end
	end

	// word interleave, bank bits sit right above the byte offset
	assign rd_bank = araddr[mem_pkg::BYTE_OFFSET_BITS +: BANK_W];
	assign wr_bank = awaddr[mem_pkg::BYTE_OFFSET_BITS +: BANK_W];

	// index is whatever is left above the bank bits
	always_comb begin
		rd_req.index = mem_pkg::index_t'(araddr >> INDEX_SHIFT);
		wr_req.index = mem_pkg::index_t'(awaddr >> INDEX_SHIFT);
		wr_req.data  = wdata;
		wr_req.strb  = wstrb;
	end

	// a request goes out only while the order queue has space
	assign rd_go = live && arvalid && !rd_order_full;
	// AW and W travel as one beat
	assign wr_go = live && awvalid && wvalid && !wr_order_full;

	// valid only toward the addressed bank
	always_comb begin
		rd_req_valid = '0;
		wr_req_valid = '0;
		if (rd_go) begin
			rd_req_valid[rd_bank] = 1'b1;
		end
		if (wr_go) begin
			wr_req_valid[wr_bank] = 1'b1;
		end
	end

	// ready mirrors the target bank
	assign arready = rd_go && rd_req_ready[rd_bank];
	assign awready = wr_go && wr_req_ready[wr_bank];
	assign wready  = awready;

	// one pulse per transfer, tagged with its bank
	assign rd_issue      = arready;
	assign rd_issue_bank = rd_bank;
	assign wr_issue      = awready;
	assign wr_issue_bank = wr_bank;

endmodule

`default_nettype wire

// File: hw/mem_bank.sv
`timescale 1ns/1ns
`default_nettype none

module mem_bank #(
	parameter int BANK_DEPTH = 64
) (
	input  wire logic             clk,
	input  wire logic             rst,
	// read channel
	input  wire logic             rd_req_valid,
	input  wire mem_pkg::rd_req_t rd_req,
	output logic                  rd_req_ready,
	output logic                  rd_rsp_valid,
	output mem_pkg::rd_rsp_t      rd_rsp,
	input  wire logic             rd_rsp_ready,
	// write channel
	input  wire logic             wr_req_valid,
	input  wire mem_pkg::wr_req_t wr_req,
	output logic                  wr_req_ready,
	output logic                  wr_rsp_valid,
	output mem_pkg::wr_rsp_t      wr_rsp,
	input  wire logic             wr_rsp_ready
);

	localparam int ADDR_W = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;

	// idle or holding a response, same shape for both channels
	typedef enum logic {
		ST_IDLE,
		ST_HOLD
	} state_t;

	state_t rd_state;
	state_t wr_state;

	mem_pkg::data_t mem [BANK_DEPTH];

	logic              rd_take;
	logic              wr_take;
	logic              rd_in_range;
	logic              wr_in_range;
	logic [ADDR_W-1:0] rd_addr;
	logic [ADDR_W-1:0] wr_addr;

	// range check on the full index, storage uses the low bits
	assign rd_in_range = (rd_req.index < mem_pkg::index_t'(BANK_DEPTH));
	assign wr_in_range = (wr_req.index < mem_pkg::index_t'(BANK_DEPTH));
	assign rd_addr     = rd_req.index[ADDR_W-1:0];
	assign wr_addr     = wr_req.index[ADDR_W-1:0];

	// response held until the merger takes it
	assign rd_rsp_valid = (rd_state == ST_HOLD);
	assign wr_rsp_valid = (wr_state == ST_HOLD);

	// free when empty, or when the held beat leaves this cycle
	assign rd_req_ready = (rd_state == ST_IDLE) || rd_rsp_ready;
	assign wr_req_ready = (wr_state == ST_IDLE) || wr_rsp_ready;

	assign rd_take = rd_req_valid && rd_req_ready;
	assign wr_take = wr_req_valid && wr_req_ready;

	// read fsm
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state <= ST_IDLE;
		end else if (rd_take) begin
			rd_state <= ST_HOLD;
		end else if (rd_rsp_valid && rd_rsp_ready) begin
			rd_state <= ST_IDLE;
		end
	end

	// write fsm
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_state <= ST_IDLE;
		end else if (wr_take) begin
			wr_state <= ST_HOLD;
		end else if (wr_rsp_valid && wr_rsp_ready) begin
			wr_state <= ST_IDLE;
		end
	end

	// read data register, zero data on a bad index
	always_ff @(posedge clk) begin
		if (rd_take) begin
			if (rd_in_range) begin
				rd_rsp.data <= mem[rd_addr];
				rd_rsp.resp <= mem_pkg::RESP_OKAY;
			end else begin
				rd_rsp.data <= '0;
				rd_rsp.resp <= mem_pkg::RESP_SLVERR;
			end
		end
	end

	// byte merge under the strobe, out of range leaves storage alone
	always_ff @(posedge clk) begin
		if (wr_take) begin
			if (wr_in_range) begin
				for (int b = 0; b < mem_pkg::STRB_W; b++) begin
					if (wr_req.strb[b]) begin
						mem[wr_addr][b*8 +: 8] <= wr_req.data[b*8 +: 8];
					end
				end
			end
			wr_rsp.resp <= wr_in_range ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
		end
	end

endmodule

`default_nettype wire

// File: hw/resp_merge.sv
`timescale 1ns/1ns
`default_nettype none

module resp_merge #(
	parameter int NUM_BANKS   = 4,
	parameter int ORDER_DEPTH = 8
) (
	input  wire logic                        clk,
	input  wire logic                        rst,
	// issue reports from the router
	input  wire logic                        rd_issue,
	input  wire logic [$clog2(NUM_BANKS)-1:0] rd_issue_bank,
	input  wire logic                        wr_issue,
	input  wire logic [$clog2(NUM_BANKS)-1:0] wr_issue_bank,
	output logic                             rd_order_full,
	output logic                             wr_order_full,
	// bank responses
	input  wire logic [NUM_BANKS-1:0]        rd_rsp_valid,
	input  wire mem_pkg::rd_rsp_t            rd_rsp [NUM_BANKS],
	output logic [NUM_BANKS-1:0]             rd_rsp_ready,
	input  wire logic [NUM_BANKS-1:0]        wr_rsp_valid,
	input  wire mem_pkg::wr_rsp_t            wr_rsp [NUM_BANKS],
	output logic [NUM_BANKS-1:0]             wr_rsp_ready,
	// R channel
	output logic                             rvalid,
	output mem_pkg::data_t                   rdata,
	output mem_pkg::resp_t                   rresp,
	input  wire logic                        rready,
	// B channel
	output logic                             bvalid,
	output mem_pkg::resp_t                   bresp,
	input  wire logic                        bready
);

	localparam int BANK_W = $clog2(NUM_BANKS);
	// two beats keep the output streaming
	localparam int OUT_DEPTH = 2;

	typedef logic [BANK_W-1:0] bank_id_t;

	bank_id_t         rd_head;
	bank_id_t         wr_head;
	logic             rd_order_empty;
	logic             wr_order_empty;
	logic             rd_take;
	logic             wr_take;
	logic             rd_out_full;
	logic             wr_out_full;
	logic             rd_out_empty;
	logic             wr_out_empty;
	mem_pkg::rd_rsp_t rd_out;
	mem_pkg::wr_rsp_t wr_out;

	// bank ids in request order
	resp_fifo #(.T(bank_id_t), .DEPTH(ORDER_DEPTH)) u_rd_order (
		.clk       (clk),
		.rst       (rst),
		.push      (rd_issue),
		.push_data (rd_issue_bank),
		.full      (rd_order_full),
		.pop       (rd_take),
		.pop_data  (rd_head),
		.empty     (rd_order_empty)
	);

	resp_fifo #(.T(bank_id_t), .DEPTH(ORDER_DEPTH)) u_wr_order (
		.clk       (clk),
		.rst       (rst),
		.push      (wr_issue),
		.push_data (wr_issue_bank),
		.full      (wr_order_full),
		.pop       (wr_take),
		.pop_data  (wr_head),
		.empty     (wr_order_empty)
	);

	// only the bank at the head may answer, and only with room downstream
	assign rd_take = !rd_order_empty && rd_rsp_valid[rd_head] && !rd_out_full;
	assign wr_take = !wr_order_empty && wr_rsp_valid[wr_head] && !wr_out_full;

	always_comb begin
		rd_rsp_ready = '0;
		wr_rsp_ready = '0;
		if (rd_take) begin
			rd_rsp_ready[rd_head] = 1'b1;
		end
		if (wr_take) begin
			wr_rsp_ready[wr_head] = 1'b1;
		end
	end

	// output buffers, one edge behind the take
	resp_fifo #(.T(mem_pkg::rd_rsp_t), .DEPTH(OUT_DEPTH)) u_rd_out (
		.clk       (clk),
		.rst       (rst),
		.push      (rd_take),
		.push_data (rd_rsp[rd_head]),
		.full      (rd_out_full),
		.pop       (rvalid && rready),
		.pop_data  (rd_out),
		.empty     (rd_out_empty)
	);

	resp_fifo #(.T(mem_pkg::wr_rsp_t), .DEPTH(OUT_DEPTH)) u_wr_out (
		.clk       (clk),
		.rst       (rst),
		.push      (wr_take),
		.push_data (wr_rsp[wr_head]),
		.full      (wr_out_full),
		.pop       (bvalid && bready),
		.pop_data  (wr_out),
		.empty     (wr_out_empty)
	);

	// outside channels straight off the fifo heads
	assign rvalid = !rd_out_empty;
	assign rdata  = rd_out.data;
	assign rresp  = rd_out.resp;
	assign bvalid = !wr_out_empty;
	assign bresp  = wr_out.resp;

endmodule

`default_nettype wire

// File: hw/banked_mem_top.sv
`timescale 1ns/1ns
`default_nettype none

module banked_mem_top #(
	parameter int NUM_BANKS   = 4,
	parameter int BANK_DEPTH  = 64,
	parameter int ORDER_DEPTH = 8
) (
	input  wire logic           clk,
	input  wire logic           rst,
	input  wire logic           arvalid,
	input  wire mem_pkg::addr_t araddr,
	output logic                arready,
	output logic                rvalid,
	output mem_pkg::data_t      rdata,
	output mem_pkg::resp_t      rresp,
	input  wire logic           rready,
	input  wire logic           awvalid,
	input  wire mem_pkg::addr_t awaddr,
	output logic                awready,
	input  wire logic           wvalid,
	input  wire mem_pkg::data_t wdata,
	input  wire mem_pkg::strb_t wstrb,
	output logic                wready,
	output logic                bvalid,
	output mem_pkg::resp_t      bresp,
	input  wire logic           bready
);

	localparam int BANK_W = $clog2(NUM_BANKS);

	// router to banks
	logic [NUM_BANKS-1:0] rd_req_valid;
	logic [NUM_BANKS-1:0] rd_req_ready;
	logic [NUM_BANKS-1:0] wr_req_valid;
	logic [NUM_BANKS-1:0] wr_req_ready;
	mem_pkg::rd_req_t     rd_req;
	mem_pkg::wr_req_t     wr_req;

	// router to merger
	logic              rd_issue;
	logic              wr_issue;
	logic [BANK_W-1:0] rd_issue_bank;
	logic [BANK_W-1:0] wr_issue_bank;
	logic              rd_order_full;
	logic              wr_order_full;

	// banks to merger
	logic [NUM_BANKS-1:0] rd_rsp_valid;
	logic [NUM_BANKS-1:0] rd_rsp_ready;
	logic [NUM_BANKS-1:0] wr_rsp_valid;
	logic [NUM_BANKS-1:0] wr_rsp_ready;
	mem_pkg::rd_rsp_t     rd_rsp [NUM_BANKS];
	mem_pkg::wr_rsp_t     wr_rsp [NUM_BANKS];

	bank_router #(.NUM_BANKS(NUM_BANKS)) u_router (
		.clk           (clk),
		.rst           (rst),
		.arvalid       (arvalid),
		.araddr        (araddr),
		.arready       (arready),
		.awvalid       (awvalid),
		.awaddr        (awaddr),
		.awready       (awready),
		.wvalid        (wvalid),
		.wdata         (wdata),
		.wstrb         (wstrb),
		.wready        (wready),
		.rd_req_valid  (rd_req_valid),
		.rd_req        (rd_req),
		.rd_req_ready  (rd_req_ready),
		.wr_req_valid  (wr_req_valid),
		.wr_req        (wr_req),
		.wr_req_ready  (wr_req_ready),
		.rd_issue      (rd_issue),
		.rd_issue_bank (rd_issue_bank),
		.wr_issue      (wr_issue),
		.wr_issue_bank (wr_issue_bank),
		.rd_order_full (rd_order_full),
		.wr_order_full (wr_order_full)
	);

	// request bus is shared, valid picks the bank
	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
		mem_bank #(.BANK_DEPTH(BANK_DEPTH)) u_bank (
			.clk          (clk),
			.rst          (rst),
			.rd_req_valid (rd_req_valid[i]),
			.rd_req       (rd_req),
			.rd_req_ready (rd_req_ready[i]),
			.rd_rsp_valid (rd_rsp_valid[i]),
			.rd_rsp       (rd_rsp[i]),
			.rd_rsp_ready (rd_rsp_ready[i]),
			.wr_req_valid (wr_req_valid[i]),
			.wr_req       (wr_req),
			.wr_req_ready (wr_req_ready[i]),
			.wr_rsp_valid (wr_rsp_valid[i]),
			.wr_rsp       (wr_rsp[i]),
			.wr_rsp_ready (wr_rsp_ready[i])
		);
	end

	resp_merge #(
		.NUM_BANKS   (NUM_BANKS),
		.ORDER_DEPTH (ORDER_DEPTH)
	) u_merge (
		.clk           (clk),
		.rst           (rst),
		.rd_issue      (rd_issue),
		.rd_issue_bank (rd_issue_bank),
		.wr_issue      (wr_issue),
		.wr_issue_bank (wr_issue_bank),
		.rd_order_full (rd_order_full),
		.wr_order_full (wr_order_full),
		.rd_rsp_valid  (rd_rsp_valid),
		.rd_rsp        (rd_rsp),
		.rd_rsp_ready  (rd_rsp_ready),
		.wr_rsp_valid  (wr_rsp_valid),
		.wr_rsp        (wr_rsp),
		.wr_rsp_ready  (wr_rsp_ready),
		.rvalid        (rvalid),
		.rdata         (rdata),
		.rresp         (rresp),
		.rready        (rready),
		.bvalid        (bvalid),
		.bresp         (bresp),
		.bready        (bready)
	);

endmodule

`default_nettype wire

// File: sim/tb_banked_mem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_banked_mem;

	localparam int NUM_ENTRIES = 36;
	localparam int PASSES = 3;
	// cycles allowed per request under the worst run of stalls
	localparam int STALL_ALLOW = 40;
	localparam int CYCLE_LIMIT = NUM_ENTRIES * PASSES * STALL_ALLOW + 100;
	localparam int SAMPLE_DELAY = 1;
	localparam logic [31:0] SEED = 32'h306521cd;

	// AXI response codes
	localparam logic [1:0] RSP_OK = 2'b00;
	localparam logic [1:0] RSP_ERR = 2'b10;

	// one table row where exp_data only matters for reads
	typedef struct packed {
		logic        is_write;
		logic [31:0] addr;
		logic [63:0] wdata;
		logic [7:0]  strb;
		logic [63:0] exp_data;
		logic [1:0]  exp_resp;
	} entry_t;

	logic        clk;
	logic        rst;
	logic        arvalid;
	logic [31:0] araddr;
	logic        arready;
	logic        rvalid;
	logic [63:0] rdata;
	logic [1:0]  rresp;
	logic        rready;
	logic        awvalid;
	logic [31:0] awaddr;
	logic        awready;
	logic        wvalid;
	logic [63:0] wdata;
	logic [7:0]  wstrb;
	logic        wready;
	logic        bvalid;
	logic [1:0]  bresp;
	logic        bready;

	entry_t      table_mem [NUM_ENTRIES];
	int          n_loaded;
	int          errors;
	int          cycles;
	int          rd_sent;
	int          wr_sent;
	int          rd_beats;
	int          wr_beats;
	// expected beats per channel in arrival order
	logic [63:0] rd_exp_data [$];
	logic [1:0]  rd_exp_resp [$];
	logic [1:0]  wr_exp_resp [$];

	banked_mem_top #(
		.NUM_BANKS   (4),
		.BANK_DEPTH  (64),
		.ORDER_DEPTH (8)
	) dut0 (
		.clk     (clk),
		.rst     (rst),
		.arvalid (arvalid),
		.araddr  (araddr),
		.arready (arready),
		.rvalid  (rvalid),
		.rdata   (rdata),
		.rresp   (rresp),
		.rready  (rready),
		.awvalid (awvalid),
		.awaddr  (awaddr),
		.awready (awready),
		.wvalid  (wvalid),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wready  (wready),
		.bvalid  (bvalid),
		.bresp   (bresp),
		.bready  (bready)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	// hang guard
	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout after %0d cycles with %0d reads and %0d writes still open",
				cycles, rd_exp_data.size(), wr_exp_resp.size());
			$display("Test failures found");
			$finish;
		end
	end

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("Fail %0t ns: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic add_write(input logic [31:0] addr, input logic [63:0] data,
			input logic [7:0] strb, input logic [1:0] resp);
		entry_t e;
		e.is_write = 1'b1;
		e.addr     = addr;
		e.wdata    = data;
		e.strb     = strb;
		e.exp_data = '0;
		e.exp_resp = resp;
		table_mem[n_loaded] = e;
		n_loaded++;
	endtask

	task automatic add_read(input logic [31:0] addr, input logic [63:0] data,
			input logic [1:0] resp);
		entry_t e;
		e.is_write = 1'b0;
		e.addr     = addr;
		e.wdata    = '0;
		e.strb     = '0;
		e.exp_data = data;
		e.exp_resp = resp;
		table_mem[n_loaded] = e;
		n_loaded++;
	endtask

	// word w sits in bank w%4 at index w/4 of 64
	task automatic load_table();
		// full word into each bank and read it back
		add_write(32'h000, 64'h0011223344556677, 8'hff, RSP_OK);
		add_write(32'h008, 64'h8899aabbccddeeff, 8'hff, RSP_OK);
		add_write(32'h010, 64'h0123456789abcdef, 8'hff, RSP_OK);
		add_write(32'h018, 64'hfedcba9876543210, 8'hff, RSP_OK);
		add_read(32'h000, 64'h0011223344556677, RSP_OK);
		add_read(32'h008, 64'h8899aabbccddeeff, RSP_OK);
		add_read(32'h010, 64'h0123456789abcdef, RSP_OK);
		add_read(32'h018, 64'hfedcba9876543210, RSP_OK);
		// full word then low half then top byte only
		add_write(32'h020, 64'haaaaaaaaaaaaaaaa, 8'hff, RSP_OK);
		add_write(32'h020, 64'h5555555555555555, 8'h0f, RSP_OK);
		add_write(32'h020, 64'hc300000000000000, 8'h80, RSP_OK);
		add_read(32'h020, 64'hc3aaaaaa55555555, RSP_OK);
		// scattered bytes 1 3 4 6
		add_write(32'h028, 64'h0f0f0f0f0f0f0f0f, 8'hff, RSP_OK);
		add_write(32'h028, 64'hffffffffffffffff, 8'h5a, RSP_OK);
		add_read(32'h028, 64'h0fff0fffff0fff0f, RSP_OK);
		// index 64 and 127 whose low bits alias words 0x000 and 0x7f8
		add_write(32'h800, 64'hdeadbeefdeadbeef, 8'hff, RSP_ERR);
		add_read(32'h800, 64'h0, RSP_ERR);
		add_write(32'hff8, 64'h0000000000000001, 8'hff, RSP_ERR);
		// byte offset bits are ignored
		add_read(32'h00f, 64'h8899aabbccddeeff, RSP_OK);
		add_read(32'h000, 64'h0011223344556677, RSP_OK);
		// top of every bank and the middle of banks 0 and 1
		add_write(32'h7f8, 64'h7777666655554444, 8'hff, RSP_OK);
		add_write(32'h7f0, 64'h3333222211110000, 8'hff, RSP_OK);
		add_write(32'h7e8, 64'ha5a5a5a5a5a5a5a5, 8'hff, RSP_OK);
		add_write(32'h7e0, 64'h5a5a5a5a5a5a5a5a, 8'hff, RSP_OK);
		add_write(32'h400, 64'h0000ffff0000ffff, 8'hff, RSP_OK);
		add_write(32'h408, 64'hffff0000ffff0000, 8'hff, RSP_OK);
		// read burst across banks
		add_read(32'h7f8, 64'h7777666655554444, RSP_OK);
		add_read(32'h7f0, 64'h3333222211110000, RSP_OK);
		add_read(32'h7e8, 64'ha5a5a5a5a5a5a5a5, RSP_OK);
		add_read(32'h7e0, 64'h5a5a5a5a5a5a5a5a, RSP_OK);
		add_read(32'h400, 64'h0000ffff0000ffff, RSP_OK);
		add_read(32'h408, 64'hffff0000ffff0000, RSP_OK);
		add_read(32'h028, 64'h0fff0fffff0fff0f, RSP_OK);
		add_read(32'h018, 64'hfedcba9876543210, RSP_OK);
		add_read(32'h020, 64'hc3aaaaaa55555555, RSP_OK);
		add_read(32'hff8, 64'h0, RSP_ERR);
	endtask

	// starts and returns right after a falling edge
	task automatic send_read(input logic [31:0] addr);
		logic accepted;
		accepted = 1'b0;
		arvalid = 1'b1;
		araddr  = addr;
		while (!accepted) begin
			#SAMPLE_DELAY;
			accepted = arready;
			@(posedge clk);
		end
		@(negedge clk);
		arvalid = 1'b0;
		araddr  = '0;
	endtask

	// AW and W offered together
	task automatic send_write(input logic [31:0] addr, input logic [63:0] data,
			input logic [7:0] strb);
		logic accepted;
		accepted = 1'b0;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		awaddr  = addr;
		wdata   = data;
		wstrb   = strb;
		while (!accepted) begin
			#SAMPLE_DELAY;
			accepted = awready && wready;
			@(posedge clk);
		end
		@(negedge clk);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		awaddr  = '0;
		wdata   = '0;
		wstrb   = '0;
	endtask

	task automatic apply_entry(input entry_t e);
		if (e.is_write) begin
			wr_exp_resp.push_back(e.exp_resp);
			wr_sent++;
			send_write(e.addr, e.wdata, e.strb);
		end else begin
			rd_exp_data.push_back(e.exp_data);
			rd_exp_resp.push_back(e.exp_resp);
			rd_sent++;
			send_read(e.addr);
		end
	endtask

	// mostly ready with the odd long stall to back up the queues
	task automatic drive_ready_stalls();
		int r_stall = 0;
		int b_stall = 0;
		forever begin
			@(negedge clk);
			if (r_stall > 0) begin
				r_stall--;
				rready = 1'b0;
			end else if ($urandom_range(0, 7) == 0) begin
				r_stall = $urandom_range(1, 20);
				rready = 1'b0;
			end else begin
				rready = 1'b1;
			end
			if (b_stall > 0) begin
				b_stall--;
				bready = 1'b0;
			end else if ($urandom_range(0, 7) == 0) begin
				b_stall = $urandom_range(1, 20);
				bready = 1'b0;
			end else begin
				bready = 1'b1;
			end
		end
	endtask

	// sampled mid low phase before the beat moves on the rising edge
	task automatic watch_read();
		forever begin
			@(negedge clk);
			#SAMPLE_DELAY;
			if (!rst && rvalid && rready) begin
				rd_beats++;
				if (rd_exp_data.size() == 0) begin
					$display("read beat at %0t ns arrived with no read outstanding", $time);
					errors++;
				end else begin
					check_value(rdata, rd_exp_data.pop_front(), "read data");
					check_value(64'(rresp), 64'(rd_exp_resp.pop_front()), "read response");
				end
			end
		end
	endtask

	task automatic watch_write();
		forever begin
			@(negedge clk);
			#SAMPLE_DELAY;
			if (!rst && bvalid && bready) begin
				wr_beats++;
				if (wr_exp_resp.size() == 0) begin
					$display("write beat at %0t ns arrived with no write outstanding", $time);
					errors++;
				end else begin
					check_value(64'(bresp), 64'(wr_exp_resp.pop_front()), "write response");
				end
			end
		end
	endtask

	initial begin : main
		int gap;
		void'($urandom(SEED));
		errors   = 0;
		cycles   = 0;
		n_loaded = 0;
		rd_sent  = 0;
		wr_sent  = 0;
		rd_beats = 0;
		wr_beats = 0;
		rst     = 1'b1;
		arvalid = 1'b0;
		araddr  = '0;
		rready  = 1'b0;
		awvalid = 1'b0;
		awaddr  = '0;
		wvalid  = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		bready  = 1'b0;
		load_table();
		fork
			drive_ready_stalls();
			watch_read();
			watch_write();
		join_none
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// quiet outputs until the first request
		repeat (5) begin
			@(negedge clk);
			#SAMPLE_DELAY;
			check_value(64'(rvalid), 64'(0), "rvalid while idle");
			check_value(64'(bvalid), 64'(0), "bvalid while idle");
		end
		@(negedge clk);
		for (int p = 0; p < PASSES; p++) begin
			for (int i = 0; i < NUM_ENTRIES; i++) begin
				// back to back three times out of four
				gap = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 3) : 0;
				repeat (gap) @(negedge clk);
				apply_entry(table_mem[i]);
			end
		end
		// drain and look for stray beats
		while (rd_exp_data.size() != 0 || wr_exp_resp.size() != 0) begin
			@(negedge clk);
		end
		repeat (30) @(negedge clk);
		check_value(64'(rd_beats), 64'(rd_sent), "read beat count");
		check_value(64'(wr_beats), 64'(wr_sent), "write beat count");
		$display("errors %0d, read beats %0d of %0d, write beats %0d of %0d",
			errors, rd_beats, rd_sent, wr_beats, wr_sent);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
hw/mem_pkg.sv
hw/resp_fifo.sv
hw/bank_router.sv
hw/mem_bank.sv
hw/resp_merge.sv
hw/banked_mem_top.sv
sim/tb_banked_mem.sv

// File: Makefile
TOP := tb_banked_mem

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): sim.f hw/*.sv sim/*.sv
	verilator --binary --timing -j 0 -f sim.f --top-module $(TOP)

# the log decides pass or fail
run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
